/* id_remap_pkg.sv */
// AXI ID remapper shared definitions
// ID, address and data widths, channel payload structs and the
// request and response bundles of the slave and master ports
package id_remap_pkg;

  // Slave-port IDs are wide, master-port IDs are compact
  localparam int unsigned SlvIdWidth = 4;
  localparam int unsigned MstIdWidth = 2;
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 32;

  typedef logic [SlvIdWidth-1:0] slv_id_t;
  typedef logic [MstIdWidth-1:0] mst_id_t;
  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [DataWidth-1:0]  data_t;
  typedef logic [7:0]            len_t;
  typedef logic [1:0]            axi_resp_t;

  // Address channel, shared by AR and AW
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_ax_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ax_t;

  typedef struct packed {
    slv_id_t   id;
    axi_resp_t resp;
  } slv_b_t;

  typedef struct packed {
    mst_id_t   id;
    axi_resp_t resp;
  } mst_b_t;

  typedef struct packed {
    slv_id_t   id;
    data_t     data;
    axi_resp_t resp;
    logic      last;
  } slv_r_t;

  typedef struct packed {
    mst_id_t   id;
    data_t     data;
    axi_resp_t resp;
    logic      last;
  } mst_r_t;

  // Port bundles, W is not part of this design
  typedef struct packed {
    slv_ax_t aw;
    logic    aw_valid;
    slv_ax_t ar;
    logic    ar_valid;
    logic    b_ready;
    logic    r_ready;
  } slv_req_t;

  typedef struct packed {
    logic   aw_ready;
    logic   ar_ready;
    slv_b_t b;
    logic   b_valid;
    slv_r_t r;
    logic   r_valid;
  } slv_rsp_t;

  typedef struct packed {
    mst_ax_t aw;
    logic    aw_valid;
    mst_ax_t ar;
    logic    ar_valid;
    logic    b_ready;
    logic    r_ready;
  } mst_req_t;

  typedef struct packed {
    logic   aw_ready;
    logic   ar_ready;
    mst_b_t b;
    logic   b_valid;
    mst_r_t r;
    logic   r_valid;
  } mst_rsp_t;

endpackage

/* id_remap_table.sv */
// ID remap table for one direction
// One entry per master ID holds the slave ID and a count of bursts in flight.
// Provides the lowest free master ID, the match for a slave ID and the
// slave ID behind a completing master ID
module id_remap_table import id_remap_pkg::*; #(
  parameter int unsigned TableSize = 4,
  parameter int unsigned MaxTxns   = 3
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    push_i,
  input  slv_id_t push_inp_id_i,
  input  mst_id_t push_oup_id_i,
  input  slv_id_t lookup_inp_id_i,
  input  logic    pop_i,
  input  mst_id_t pop_oup_id_i,
  output mst_id_t free_oup_id_o,
  output logic    full_o,
  output logic    exists_o,
  output logic    exists_full_o,
  output mst_id_t exists_oup_id_o,
  output slv_id_t pop_inp_id_o
);

  localparam int unsigned CntWidth = $clog2(MaxTxns + 1);
  typedef logic [CntWidth-1:0] cnt_t;

  slv_id_t [TableSize-1:0] inp_id_q;
  cnt_t    [TableSize-1:0] cnt_q;
  cnt_t    [TableSize-1:0] cnt_d;

  // Scan downwards so that the lowest free entry wins
  always_comb begin
    free_oup_id_o = '0;
    full_o        = 1'b1;
    for (int i = TableSize - 1; i >= 0; i--) begin
      if (cnt_q[i] == '0) begin
        free_oup_id_o = mst_id_t'(i);
        full_o        = 1'b0;
      end
    end
  end

  // An entry only counts as a match while it still has bursts in flight.
  // The mapping is one to one, so at most one entry can match
  always_comb begin
    exists_o        = 1'b0;
    exists_full_o   = 1'b0;
    exists_oup_id_o = '0;
    for (int i = 0; i < TableSize; i++) begin
      if (cnt_q[i] != '0 && inp_id_q[i] == lookup_inp_id_i) begin
        exists_o        = 1'b1;
        exists_full_o   = (cnt_q[i] == cnt_t'(MaxTxns));
        exists_oup_id_o = mst_id_t'(i);
      end
    end
  end

  always_comb begin
    pop_inp_id_o = '0;
    for (int i = 0; i < TableSize; i++) begin
      if (pop_oup_id_i == mst_id_t'(i)) begin
        pop_inp_id_o = inp_id_q[i];
      end
    end
  end

  // Push and pop may hit the same entry in one cycle and then cancel out
  always_comb begin
    logic push_hit;
    logic pop_hit;
    cnt_d = cnt_q;
    for (int i = 0; i < TableSize; i++) begin
      push_hit = push_i && (push_oup_id_i == mst_id_t'(i));
      pop_hit  = pop_i && (pop_oup_id_i == mst_id_t'(i));
      if (push_hit && !pop_hit) begin
        cnt_d[i] = cnt_q[i] + cnt_t'(1);
      end else if (pop_hit && !push_hit) begin
        cnt_d[i] = cnt_q[i] - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // The slave ID is only meaningful while the counter is nonzero
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < TableSize; i++) begin
      if (push_i && push_oup_id_i == mst_id_t'(i)) begin
        inp_id_q[i] <= push_inp_id_i;
      end
    end
  end

endmodule

/* id_remap_issue.sv */
// Address channel issue unit
// Grants a slave request when the remap table has room, picks the reused or
// the lowest free master ID and holds the request while the master stalls
module id_remap_issue import id_remap_pkg::*; #(
  parameter int unsigned TableSize = 4,
  parameter int unsigned MaxTxns   = 3
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    slv_valid_i,
  input  slv_ax_t slv_ax_i,
  input  logic    mst_ready_i,
  input  logic    exists_i,
  input  mst_id_t exists_oup_id_i,
  input  logic    exists_full_i,
  input  mst_id_t free_oup_id_i,
  input  logic    full_i,
  output logic    slv_ready_o,
  output logic    mst_valid_o,
  output mst_ax_t mst_ax_o,
  output logic    push_o,
  output mst_id_t push_oup_id_o
);

  typedef enum logic {
    st_idle,
    st_hold
  } state_e;

  state_e  state_q, state_d;
  mst_id_t hold_id_q;
  logic    grant;
  mst_id_t new_id;

  // An ID in flight must keep its master ID to preserve ordering
  assign grant  = exists_i ? !exists_full_i : !full_i;
  assign new_id = exists_i ? exists_oup_id_i : free_oup_id_i;

  always_comb begin
    state_d       = state_q;
    mst_valid_o   = 1'b0;
    push_o        = 1'b0;
    push_oup_id_o = new_id;
    mst_ax_o.id   = new_id;
    mst_ax_o.addr = slv_ax_i.addr;
    mst_ax_o.len  = slv_ax_i.len;
    unique case (state_q)
      st_idle: begin
        if (slv_valid_i && grant) begin
          mst_valid_o = 1'b1;
          push_o      = 1'b1;
          if (!mst_ready_i) begin
            state_d = st_hold;
          end
        end
      end
      st_hold: begin
        // Already pushed, only keep the request stable until accepted
        mst_valid_o = 1'b1;
        mst_ax_o.id = hold_id_q;
        if (mst_ready_i) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  assign slv_ready_o = mst_valid_o && mst_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && push_o) begin
      hold_id_q <= new_id;
    end
  end

endmodule

/* id_remap_resp.sv */
// Response ID restore for B and R
// Replaces master IDs with the slave IDs from the tables and raises the
// table pops when a write response or the last read beat completes
module id_remap_resp import id_remap_pkg::*; (
  input  logic    slv_b_ready_i,
  input  logic    slv_r_ready_i,
  input  mst_b_t  mst_b_i,
  input  logic    mst_b_valid_i,
  input  mst_r_t  mst_r_i,
  input  logic    mst_r_valid_i,
  input  slv_id_t wr_inp_id_i,
  input  slv_id_t rd_inp_id_i,
  output slv_b_t  slv_b_o,
  output logic    slv_b_valid_o,
  output slv_r_t  slv_r_o,
  output logic    slv_r_valid_o,
  output logic    mst_b_ready_o,
  output logic    mst_r_ready_o,
  output logic    wr_pop_o,
  output logic    rd_pop_o,
  output mst_id_t wr_pop_oup_id_o,
  output mst_id_t rd_pop_oup_id_o
);

  // The tables are looked up with the master ID of the current response
  assign wr_pop_oup_id_o = mst_b_i.id;
  assign rd_pop_oup_id_o = mst_r_i.id;

  assign slv_b_o.id      = wr_inp_id_i;
  assign slv_b_o.resp    = mst_b_i.resp;
  assign slv_b_valid_o   = mst_b_valid_i;
  assign mst_b_ready_o   = slv_b_ready_i;

  assign slv_r_o.id      = rd_inp_id_i;
  assign slv_r_o.data    = mst_r_i.data;
  assign slv_r_o.resp    = mst_r_i.resp;
  assign slv_r_o.last    = mst_r_i.last;
  assign slv_r_valid_o   = mst_r_valid_i;
  assign mst_r_ready_o   = slv_r_ready_i;

  // A write burst ends with its single B
  assign wr_pop_o = mst_b_valid_i && slv_b_ready_i;

  // A read burst keeps its entry until the last beat is accepted
  assign rd_pop_o = mst_r_valid_i && slv_r_ready_i && mst_r_i.last;

endmodule

/* id_remap_top.sv */
// AXI ID remapper top level
// Maps 4-bit slave-port IDs onto 2-bit master-port IDs with one remap
// table and issue unit per direction and restores IDs on B and R
module id_remap_top import id_remap_pkg::*; #(
  parameter int unsigned TableSize = 4,
  parameter int unsigned MaxTxns   = 3
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  slv_req_t slv_req_i,
  output slv_rsp_t slv_rsp_o,
  output mst_req_t mst_req_o,
  input  mst_rsp_t mst_rsp_i
);

  // Write direction table interface
  mst_id_t wr_free_id, wr_exists_id, wr_push_id, wr_pop_id;
  logic    wr_full, wr_exists, wr_exists_full, wr_push, wr_pop;
  slv_id_t wr_pop_inp_id;

  // Read direction table interface
  mst_id_t rd_free_id, rd_exists_id, rd_push_id, rd_pop_id;
  logic    rd_full, rd_exists, rd_exists_full, rd_push, rd_pop;
  slv_id_t rd_pop_inp_id;

  mst_ax_t aw_ax, ar_ax;
  logic    aw_valid, ar_valid, aw_ready, ar_ready;
  slv_b_t  slv_b;
  slv_r_t  slv_r;
  logic    slv_b_valid, slv_r_valid, mst_b_ready, mst_r_ready;

  id_remap_table #(
    .TableSize ( TableSize ),
    .MaxTxns   ( MaxTxns   )
  ) u_wr_table (
    .clk_i,
    .rst_ni,
    .push_i          ( wr_push         ),
    .push_inp_id_i   ( slv_req_i.aw.id ),
    .push_oup_id_i   ( wr_push_id      ),
    .lookup_inp_id_i ( slv_req_i.aw.id ),
    .pop_i           ( wr_pop          ),
    .pop_oup_id_i    ( wr_pop_id       ),
    .free_oup_id_o   ( wr_free_id      ),
    .full_o          ( wr_full         ),
    .exists_o        ( wr_exists       ),
    .exists_full_o   ( wr_exists_full  ),
    .exists_oup_id_o ( wr_exists_id    ),
    .pop_inp_id_o    ( wr_pop_inp_id   )
  );

  id_remap_table #(
    .TableSize ( TableSize ),
    .MaxTxns   ( MaxTxns   )
  ) u_rd_table (
    .clk_i,
    .rst_ni,
    .push_i          ( rd_push         ),
    .push_inp_id_i   ( slv_req_i.ar.id ),
    .push_oup_id_i   ( rd_push_id      ),
    .lookup_inp_id_i ( slv_req_i.ar.id ),
    .pop_i           ( rd_pop          ),
    .pop_oup_id_i    ( rd_pop_id       ),
    .free_oup_id_o   ( rd_free_id      ),
    .full_o          ( rd_full         ),
    .exists_o        ( rd_exists       ),
    .exists_full_o   ( rd_exists_full  ),
    .exists_oup_id_o ( rd_exists_id    ),
    .pop_inp_id_o    ( rd_pop_inp_id   )
  );

  id_remap_issue #(
    .TableSize ( TableSize ),
    .MaxTxns   ( MaxTxns   )
  ) u_aw_issue (
    .clk_i,
    .rst_ni,
    .slv_valid_i     ( slv_req_i.aw_valid ),
    .slv_ax_i        ( slv_req_i.aw       ),
    .mst_ready_i     ( mst_rsp_i.aw_ready ),
    .exists_i        ( wr_exists          ),
    .exists_oup_id_i ( wr_exists_id       ),
    .exists_full_i   ( wr_exists_full     ),
    .free_oup_id_i   ( wr_free_id         ),
    .full_i          ( wr_full            ),
    .slv_ready_o     ( aw_ready           ),
    .mst_valid_o     ( aw_valid           ),
    .mst_ax_o        ( aw_ax              ),
    .push_o          ( wr_push            ),
    .push_oup_id_o   ( wr_push_id         )
  );

  id_remap_issue #(
    .TableSize ( TableSize ),
    .MaxTxns   ( MaxTxns   )
  ) u_ar_issue (
    .clk_i,
    .rst_ni,
    .slv_valid_i     ( slv_req_i.ar_valid ),
    .slv_ax_i        ( slv_req_i.ar       ),
    .mst_ready_i     ( mst_rsp_i.ar_ready ),
    .exists_i        ( rd_exists          ),
    .exists_oup_id_i ( rd_exists_id       ),
    .exists_full_i   ( rd_exists_full     ),
    .free_oup_id_i   ( rd_free_id         ),
    .full_i          ( rd_full            ),
    .slv_ready_o     ( ar_ready           ),
    .mst_valid_o     ( ar_valid           ),
    .mst_ax_o        ( ar_ax              ),
    .push_o          ( rd_push            ),
    .push_oup_id_o   ( rd_push_id         )
  );

  id_remap_resp u_resp (
    .slv_b_ready_i   ( slv_req_i.b_ready ),
    .slv_r_ready_i   ( slv_req_i.r_ready ),
    .mst_b_i         ( mst_rsp_i.b       ),
    .mst_b_valid_i   ( mst_rsp_i.b_valid ),
    .mst_r_i         ( mst_rsp_i.r       ),
    .mst_r_valid_i   ( mst_rsp_i.r_valid ),
    .wr_inp_id_i     ( wr_pop_inp_id     ),
    .rd_inp_id_i     ( rd_pop_inp_id     ),
    .slv_b_o         ( slv_b             ),
    .slv_b_valid_o   ( slv_b_valid       ),
    .slv_r_o         ( slv_r             ),
    .slv_r_valid_o   ( slv_r_valid       ),
    .mst_b_ready_o   ( mst_b_ready       ),
    .mst_r_ready_o   ( mst_r_ready       ),
    .wr_pop_o        ( wr_pop            ),
    .rd_pop_o        ( rd_pop            ),
    .wr_pop_oup_id_o ( wr_pop_id         ),
    .rd_pop_oup_id_o ( rd_pop_id         )
  );

  assign mst_req_o.aw       = aw_ax;
  assign mst_req_o.aw_valid = aw_valid;
  assign mst_req_o.ar       = ar_ax;
  assign mst_req_o.ar_valid = ar_valid;
  assign mst_req_o.b_ready  = mst_b_ready;
  assign mst_req_o.r_ready  = mst_r_ready;

  assign slv_rsp_o.aw_ready = aw_ready;
  assign slv_rsp_o.ar_ready = ar_ready;
  assign slv_rsp_o.b        = slv_b;
  assign slv_rsp_o.b_valid  = slv_b_valid;
  assign slv_rsp_o.r        = slv_r;
  assign slv_rsp_o.r_valid  = slv_r_valid;

endmodule

/* tb_id_remap_assert.sv */
// Bound checks for the AXI ID remapper
// Address requests stay stable under back-pressure and every
// handshake passes through the remapper one to one
module tb_id_remap_assert import id_remap_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input slv_req_t slv_req_i,
  input slv_rsp_t slv_rsp_i,
  input mst_req_t mst_req_i,
  input mst_rsp_t mst_rsp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mst_req_i.aw_valid && !mst_rsp_i.aw_ready) |=>
    (mst_req_i.aw_valid && $stable(mst_req_i.aw.id)))
    else $error("AW valid or ID changed while the master port stalled");

  a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mst_req_i.ar_valid && !mst_rsp_i.ar_ready) |=>
    (mst_req_i.ar_valid && $stable(mst_req_i.ar.id)))
    else $error("AR valid or ID changed while the master port stalled");

  // A held request completes on both ports in the same cycle
  a_aw_pass: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_req_i.aw_valid && slv_rsp_i.aw_ready) == (mst_req_i.aw_valid && mst_rsp_i.aw_ready))
    else $error("Slave and master AW handshakes differ");

  a_ar_pass: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_req_i.ar_valid && slv_rsp_i.ar_ready) == (mst_req_i.ar_valid && mst_rsp_i.ar_ready))
    else $error("Slave and master AR handshakes differ");

  a_b_pass: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mst_rsp_i.b_valid && mst_req_i.b_ready) |-> (slv_rsp_i.b_valid && slv_req_i.b_ready))
    else $error("Master B handshake without a slave B handshake");

  a_r_pass: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mst_rsp_i.r_valid && mst_req_i.r_ready) |-> (slv_rsp_i.r_valid && slv_req_i.r_ready))
    else $error("Master R handshake without a slave R handshake");

endmodule

bind id_remap_top tb_id_remap_assert u_assert (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .slv_req_i ( slv_req_i ),
  .slv_rsp_i ( slv_rsp_o ),
  .mst_req_i ( mst_req_o ),
  .mst_rsp_i ( mst_rsp_i )
);

/* tb_id_remap.sv */
// Testbench for the AXI ID remapper
// Random AR and AW traffic against a reordering master model, checked
// against a shadow remap table for each direction
module tb_id_remap import id_remap_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned TableSize   = 4;
  localparam int unsigned MaxTxns     = 3;
  localparam int          NumIds      = 2 ** MstIdWidth;
  localparam int          NumTxns     = 400;
  localparam int unsigned IdPool      = 6;
  localparam int unsigned MaxLen      = 4;
  localparam int          Seed        = 12316;
  localparam int unsigned ReqPct      = 60;
  localparam int unsigned ReadyPct    = 70;
  localparam int unsigned RspPct      = 50;
  localparam int          ClkPeriodNs = 4;
  localparam int          WatchdogNs  = NumTxns * 60 * ClkPeriodNs;
  localparam int          Wr          = 0;
  localparam int          Rd          = 1;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  slv_req_t slv_req;
  slv_rsp_t slv_rsp;
  mst_req_t mst_req;
  mst_rsp_t mst_rsp;

  // Shadow tables, index 0 is the write side and index 1 the read side
  slv_id_t sh_id  [2][TableSize];
  int      sh_cnt [2][TableSize];
  logic    hold    [2];
  mst_id_t hold_id [2];

  // Master model keeps one queue of bursts per master ID
  int   wr_q [NumIds][$];
  int   rd_q [NumIds][$];
  logic aw_hs, ar_hs, b_hs, r_hs;

  int aw_issued, ar_issued, aw_mst_cnt, ar_mst_cnt, b_cnt, r_last_cnt;
  int r_beat_cnt, exp_r_beats, mismatch_cnt, other_cnt;

  always #(ClkPeriodNs / 2) clk_i = ~clk_i;

  id_remap_top #(
    .TableSize ( TableSize ),
    .MaxTxns   ( MaxTxns   )
  ) DUT (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .slv_req_i ( slv_req ),
    .slv_rsp_o ( slv_rsp ),
    .mst_req_o ( mst_req ),
    .mst_rsp_i ( mst_rsp )
  );

  function automatic bit chance(input int unsigned pct);
    return ($urandom % 100) < pct;
  endfunction

  // A slave ID in flight keeps its master ID while its entry has room,
  // a new one takes the lowest entry with nothing in flight
  function automatic logic predict_grant(input int dir, input slv_id_t sid,
                                         output mst_id_t mid);
    mid = '0;
    for (int i = 0; i < TableSize; i++) begin
      if (sh_cnt[dir][i] != 0 && sh_id[dir][i] == sid) begin
        mid = mst_id_t'(i);
        return sh_cnt[dir][i] < MaxTxns;
      end
    end
    for (int i = 0; i < TableSize; i++) begin
      if (sh_cnt[dir][i] == 0) begin
        mid = mst_id_t'(i);
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic check_mst_id(input string what, input mst_id_t exp, input mst_id_t got);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %t: %s master ID expected %0d, got %0d", $time, what, exp, got);
    end
  endtask

  task automatic check_slv_id(input string what, input slv_id_t exp, input slv_id_t got);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %t: %s slave ID expected %0d, got %0d", $time, what, exp, got);
    end
  endtask

  task automatic check_grant(input string what, input logic exp, input logic got);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %t: %s expected %b, got %b", $time, what, exp, got);
    end
  endtask

  task automatic check_ax_payload(input string what, input mst_ax_t exp, input mst_ax_t got);
    if (got.addr !== exp.addr || got.len !== exp.len) begin
      mismatch_cnt++;
      $display("Mismatch at %t: %s addr/len expected %h/%0d, got %h/%0d", $time, what,
               exp.addr, exp.len, got.addr, got.len);
    end
  endtask

  task automatic check_b_payload(input string what, input slv_b_t exp, input slv_b_t got);
    if (got.resp !== exp.resp) begin
      mismatch_cnt++;
      $display("Mismatch at %t: %s resp expected %0d, got %0d", $time, what,
               exp.resp, got.resp);
    end
  endtask

  task automatic check_r_payload(input string what, input slv_r_t exp, input slv_r_t got);
    if (got.data !== exp.data || got.resp !== exp.resp || got.last !== exp.last) begin
      mismatch_cnt++;
      $display("Mismatch at %t: %s data/resp/last expected %h/%0d/%b, got %h/%0d/%b",
               $time, what, exp.data, exp.resp, exp.last, got.data, got.resp, got.last);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int got);
    if (got != exp) begin
      mismatch_cnt++;
      $display("Mismatch at %t: %s count expected %0d, got %0d", $time, what, exp, got);
    end
  endtask

  task automatic report_failure(input string msg);
    other_cnt++;
    $display("Error at %t: %s", $time, msg);
  endtask

  // Checks one address channel and updates its shadow table on a push
  task automatic check_address(input int dir, input logic slv_valid, input slv_ax_t slv_ax,
                               input logic slv_ready, input logic mst_valid,
                               input mst_ax_t mst_ax, input logic mst_ready);
    logic    exp_grant;
    mst_id_t exp_id;
    mst_ax_t exp_ax;
    string   name;
    name        = (dir == Wr) ? "AW" : "AR";
    exp_ax.addr = slv_ax.addr;
    exp_ax.len  = slv_ax.len;
    if (hold[dir]) begin
      exp_ax.id = hold_id[dir];
      check_grant({name, " valid in hold"}, 1'b1, mst_valid);
      check_grant({name, " slave ready in hold"}, mst_ready, slv_ready);
      check_mst_id({name, " in hold"}, exp_ax.id, mst_ax.id);
      check_ax_payload({name, " in hold"}, exp_ax, mst_ax);
      if (mst_ready) begin
        hold[dir] = 1'b0;
      end
    end else if (slv_valid) begin
      exp_grant = predict_grant(dir, slv_ax.id, exp_id);
      check_grant({name, " valid"}, exp_grant, mst_valid);
      check_grant({name, " slave ready"}, exp_grant && mst_ready, slv_ready);
      if (exp_grant) begin
        exp_ax.id = exp_id;
        check_mst_id(name, exp_ax.id, mst_ax.id);
        check_ax_payload(name, exp_ax, mst_ax);
        sh_id[dir][exp_id] = slv_ax.id;
        sh_cnt[dir][exp_id]++;
        if (!mst_ready) begin
          hold[dir]    = 1'b1;
          hold_id[dir] = exp_id;
        end
      end
    end else begin
      check_grant({name, " valid while idle"}, 1'b0, mst_valid);
    end
  endtask

  // Compare process, responses are checked against the table state
  // before this edge, pops are applied last
  always @(posedge clk_i) begin
    mst_id_t wr_pid;
    mst_id_t rd_pid;
    logic    wr_pop;
    logic    rd_pop;
    slv_b_t  exp_b;
    slv_r_t  exp_r;
    if (rst_ni) begin
      wr_pid = mst_rsp.b.id;
      rd_pid = mst_rsp.r.id;
      wr_pop = mst_rsp.b_valid && mst_req.b_ready;
      rd_pop = mst_rsp.r_valid && mst_req.r_ready && mst_rsp.r.last;
      // Response valid and ready pass straight through
      check_grant("B valid", mst_rsp.b_valid, slv_rsp.b_valid);
      check_grant("B ready", slv_req.b_ready, mst_req.b_ready);
      check_grant("R valid", mst_rsp.r_valid, slv_rsp.r_valid);
      check_grant("R ready", slv_req.r_ready, mst_req.r_ready);
      if (mst_rsp.b_valid && mst_req.b_ready) begin
        if (sh_cnt[Wr][wr_pid] == 0) begin
          report_failure("B response arrived for a master ID with no write in flight");
        end
        exp_b.id   = sh_id[Wr][wr_pid];
        exp_b.resp = mst_rsp.b.resp;
        check_slv_id("B", exp_b.id, slv_rsp.b.id);
        check_b_payload("B", exp_b, slv_rsp.b);
      end
      if (mst_rsp.r_valid && mst_req.r_ready) begin
        if (sh_cnt[Rd][rd_pid] == 0) begin
          report_failure("R beat arrived for a master ID with no read in flight");
        end
        exp_r.id   = sh_id[Rd][rd_pid];
        exp_r.data = mst_rsp.r.data;
        exp_r.resp = mst_rsp.r.resp;
        exp_r.last = mst_rsp.r.last;
        check_slv_id("R", exp_r.id, slv_rsp.r.id);
        check_r_payload("R", exp_r, slv_rsp.r);
      end
      check_address(Wr, slv_req.aw_valid, slv_req.aw, slv_rsp.aw_ready,
                    mst_req.aw_valid, mst_req.aw, mst_rsp.aw_ready);
      check_address(Rd, slv_req.ar_valid, slv_req.ar, slv_rsp.ar_ready,
                    mst_req.ar_valid, mst_req.ar, mst_rsp.ar_ready);
      if (wr_pop && sh_cnt[Wr][wr_pid] != 0) begin
        sh_cnt[Wr][wr_pid]--;
      end
      if (rd_pop && sh_cnt[Rd][rd_pid] != 0) begin
        sh_cnt[Rd][rd_pid]--;
      end
    end
  end

  // Master model bookkeeping, handshake flags for the drivers and
  // response counts at the slave port
  always @(posedge clk_i) begin
    aw_hs = rst_ni && slv_req.aw_valid && slv_rsp.aw_ready;
    ar_hs = rst_ni && slv_req.ar_valid && slv_rsp.ar_ready;
    b_hs  = rst_ni && mst_rsp.b_valid && mst_req.b_ready;
    r_hs  = rst_ni && mst_rsp.r_valid && mst_req.r_ready;
    if (ar_hs) begin
      exp_r_beats += int'(slv_req.ar.len) + 1;
    end
    if (rst_ni && slv_rsp.b_valid && slv_req.b_ready) begin
      b_cnt++;
    end
    if (rst_ni && slv_rsp.r_valid && slv_req.r_ready) begin
      r_beat_cnt++;
      if (slv_rsp.r.last) begin
        r_last_cnt++;
      end
    end
    if (b_hs) begin
      void'(wr_q[mst_rsp.b.id].pop_front());
    end
    if (r_hs) begin
      rd_q[mst_rsp.r.id][0] = rd_q[mst_rsp.r.id][0] - 1;
      if (rd_q[mst_rsp.r.id][0] == 0) begin
        void'(rd_q[mst_rsp.r.id].pop_front());
      end
    end
    if (rst_ni && mst_req.aw_valid && mst_rsp.aw_ready) begin
      aw_mst_cnt++;
      wr_q[mst_req.aw.id].push_back(1);
    end
    if (rst_ni && mst_req.ar_valid && mst_rsp.ar_ready) begin
      ar_mst_cnt++;
      rd_q[mst_req.ar.id].push_back(int'(mst_req.ar.len) + 1);
    end
  end

  function automatic slv_ax_t random_ax();
    slv_ax_t ax;
    ax.id   = slv_id_t'($urandom % IdPool);
    ax.addr = $urandom;
    ax.len  = len_t'($urandom % MaxLen);
    return ax;
  endfunction

  // First busy master ID from a random start, so order across IDs varies
  function automatic int pick_id(input bit rd);
    int start;
    int idx;
    start = int'($urandom % NumIds);
    for (int k = 0; k < NumIds; k++) begin
      idx = (start + k) % NumIds;
      if (rd ? rd_q[idx].size() > 0 : wr_q[idx].size() > 0) begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic drive_requests();
    if (!slv_req.aw_valid || aw_hs) begin
      slv_req.aw_valid = 1'b0;
      if (aw_issued + ar_issued < NumTxns && chance(ReqPct)) begin
        slv_req.aw       = random_ax();
        slv_req.aw_valid = 1'b1;
        aw_issued++;
      end
    end
    if (!slv_req.ar_valid || ar_hs) begin
      slv_req.ar_valid = 1'b0;
      if (aw_issued + ar_issued < NumTxns && chance(ReqPct)) begin
        slv_req.ar       = random_ax();
        slv_req.ar_valid = 1'b1;
        ar_issued++;
      end
    end
    slv_req.b_ready = chance(ReadyPct);
    slv_req.r_ready = chance(ReadyPct);
  endtask

  task automatic drive_responses();
    int id;
    mst_rsp.aw_ready = chance(ReadyPct);
    mst_rsp.ar_ready = chance(ReadyPct);
    if (!mst_rsp.b_valid || b_hs) begin
      mst_rsp.b_valid = 1'b0;
      id = pick_id(1'b0);
      if (id >= 0 && chance(RspPct)) begin
        mst_rsp.b.id    = mst_id_t'(id);
        mst_rsp.b.resp  = axi_resp_t'($urandom);
        mst_rsp.b_valid = 1'b1;
      end
    end
    if (!mst_rsp.r_valid || r_hs) begin
      mst_rsp.r_valid = 1'b0;
      id = pick_id(1'b1);
      if (id >= 0 && chance(RspPct)) begin
        mst_rsp.r.id    = mst_id_t'(id);
        mst_rsp.r.data  = $urandom;
        mst_rsp.r.resp  = axi_resp_t'($urandom);
        mst_rsp.r.last  = (rd_q[id][0] == 1);
        mst_rsp.r_valid = 1'b1;
      end
    end
  endtask

  function automatic bit all_done();
    if (aw_issued + ar_issued < NumTxns || slv_req.aw_valid || slv_req.ar_valid) begin
      return 1'b0;
    end
    if (hold[Wr] || hold[Rd]) begin
      return 1'b0;
    end
    for (int i = 0; i < NumIds; i++) begin
      if (wr_q[i].size() != 0 || rd_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    for (int i = 0; i < TableSize; i++) begin
      if (sh_cnt[Wr][i] != 0 || sh_cnt[Rd][i] != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  initial begin
    void'($urandom(Seed));
    $timeformat(-9, 1, " ns", 0);
    rst_ni  = 1'b0;
    slv_req = '0;
    mst_rsp = '0;
    for (int d = 0; d < 2; d++) begin
      hold[d]    = 1'b0;
      hold_id[d] = '0;
      for (int i = 0; i < TableSize; i++) begin
        sh_id[d][i]  = '0;
        sh_cnt[d][i] = 0;
      end
    end
    aw_issued    = 0;
    ar_issued    = 0;
    aw_mst_cnt   = 0;
    ar_mst_cnt   = 0;
    b_cnt        = 0;
    r_last_cnt   = 0;
    r_beat_cnt   = 0;
    exp_r_beats  = 0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    fork
      forever begin
        @(negedge clk_i);
        drive_requests();
        drive_responses();
      end
    join_none
    do begin
      @(posedge clk_i);
      #1;
    end while (!all_done());
    repeat (4) @(posedge clk_i);
    check_count("AW forwarded", aw_issued, aw_mst_cnt);
    check_count("AR forwarded", ar_issued, ar_mst_cnt);
    check_count("B returned", aw_issued, b_cnt);
    check_count("R bursts returned", ar_issued, r_last_cnt);
    check_count("R beats returned", exp_r_beats, r_beat_cnt);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized for the worst case of every burst stalling
  initial begin
    #(WatchdogNs);
    $display("Timeout: traffic did not drain within %0d ns", WatchdogNs);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* sim.f */
id_remap_pkg.sv
id_remap_table.sv
id_remap_issue.sv
id_remap_resp.sv
id_remap_top.sv
tb_id_remap_assert.sv
tb_id_remap.sv

/* Makefile */
# Verilator flow for the AXI ID remapper testbench
# Override any variable on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_id_remap
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, a missing pass line fails the target
run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
